// File: hdl/dispatchPkg.sv
//------------------------------------------------------------
// Dispatch shared definitions
// Field widths, class and operand encodings and the layout of
// one issue-queue payload entry
//------------------------------------------------------------
`default_nettype none

package dispatchPkg;

    // Field widths
    localparam int REG_NUM_WIDTH = 6;
    localparam int ACTIVE_PTR_WIDTH = 5;
    localparam int SUB_INFO_WIDTH = 12;
    localparam int OPCODE_WIDTH = 4;
    localparam int DISP_WIDTH = 8;

    // One enable bit per queue class
    localparam int NUM_CLASSES = 4;

    // Queue class, also the index into the class-enable mask
    typedef enum logic [1:0] {
        OPC_INT     = 2'd0,
        OPC_BRANCH  = 2'd1,
        OPC_COMPLEX = 2'd2,
        OPC_MEM     = 2'd3
    } OpClass;

    // Where a source operand comes from
    typedef enum logic [1:0] {
        OPR_REG  = 2'd0,
        OPR_IMM  = 2'd1,
        OPR_PC   = 2'd2,
        OPR_ZERO = 2'd3
    } OperandType;

    // Integer ALU operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_PASS = 4'd10
    } AluCode;

    // Stored payload, top field first
    typedef struct packed {
        OpClass                      opClass;
        logic [SUB_INFO_WIDTH-1:0]   subInfo;
        logic                        srcValidA;
        logic                        srcValidB;
        logic [REG_NUM_WIDTH-1:0]    srcRegA;
        logic [REG_NUM_WIDTH-1:0]    srcRegB;
        logic [REG_NUM_WIDTH-1:0]    dstReg;
        logic                        writeReg;
        logic [ACTIVE_PTR_WIDTH-1:0] activePtr;
    } IssueEntry;

endpackage

`default_nettype wire

// File: hdl/dispatchControl.sv
//------------------------------------------------------------
// Dispatch control
// Class-enable configuration register, stall pass-through and
// a one-cycle clear raised by a flush strobe
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dispatchControl (
    input  wire                                ctrl,
    input  wire                                reset,
    input  wire                                stallRequest,
    input  wire                                flush,
    input  wire                                cfgWrite,
    input  wire  [dispatchPkg::NUM_CLASSES-1:0] cfgEnable,
    output logic                               stall,
    output logic                               clear,
    output logic [dispatchPkg::NUM_CLASSES-1:0] classEnable
);

    // Downstream back-pressure goes straight to the stage
    assign stall = stallRequest;

    // Flush seen at one edge clears the pipe for the next cycle
    always_ff @(posedge ctrl) begin
        if (reset) begin
            clear <= 1'b0;
        end else begin
            clear <= flush;
        end
    end

    // All classes dispatch until configured otherwise
    always_ff @(posedge ctrl) begin
        if (reset) begin
            classEnable <= '1;
        end else if (cfgWrite) begin
            classEnable <= cfgEnable;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dispatchStage.sv
//------------------------------------------------------------
// Dispatch stage
// Pipeline register for the renamed lanes and per-lane
// formatting of issue-queue entries and write strobes
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dispatchStage #(
    parameter  int DISPATCH_WIDTH = 2,
    parameter  int IQ_ENTRIES = 8,
    localparam int SLOT_WIDTH = $clog2(IQ_ENTRIES)
) (
    input  wire                                 ctrl,
    input  wire                                 reset,
    input  wire                                 stall,
    input  wire                                 clear,
    input  wire  [dispatchPkg::NUM_CLASSES-1:0] classEnable,

    // Rename lanes
    input  wire  [DISPATCH_WIDTH-1:0]           renValid,
    input  dispatchPkg::OpClass [DISPATCH_WIDTH-1:0] renOpClass,
    input  wire  [DISPATCH_WIDTH-1:0][dispatchPkg::OPCODE_WIDTH-1:0] renOpCode,
    input  wire  [DISPATCH_WIDTH-1:0][dispatchPkg::DISP_WIDTH-1:0] renDisp,
    input  dispatchPkg::OperandType [DISPATCH_WIDTH-1:0] renOperandTypeA,
    input  dispatchPkg::OperandType [DISPATCH_WIDTH-1:0] renOperandTypeB,
    input  wire  [DISPATCH_WIDTH-1:0][dispatchPkg::REG_NUM_WIDTH-1:0] renSrcRegA,
    input  wire  [DISPATCH_WIDTH-1:0][dispatchPkg::REG_NUM_WIDTH-1:0] renSrcRegB,
    input  wire  [DISPATCH_WIDTH-1:0][dispatchPkg::REG_NUM_WIDTH-1:0] renDstReg,
    input  wire  [DISPATCH_WIDTH-1:0]           renWriteReg,
    input  wire  [DISPATCH_WIDTH-1:0][SLOT_WIDTH-1:0] renIssuePtr,
    input  wire  [DISPATCH_WIDTH-1:0][dispatchPkg::ACTIVE_PTR_WIDTH-1:0] renActivePtr,

    // Payload store write lanes
    output logic [DISPATCH_WIDTH-1:0]           laneWrite,
    output logic [DISPATCH_WIDTH-1:0][SLOT_WIDTH-1:0] laneWritePtr,
    output dispatchPkg::IssueEntry [DISPATCH_WIDTH-1:0] laneWriteEntry
);

    import dispatchPkg::*;

    logic [DISPATCH_WIDTH-1:0]                       pipeValid;
    OpClass [DISPATCH_WIDTH-1:0]                     pipeOpClass;
    logic [DISPATCH_WIDTH-1:0][OPCODE_WIDTH-1:0]     pipeOpCode;
    logic [DISPATCH_WIDTH-1:0][DISP_WIDTH-1:0]       pipeDisp;
    OperandType [DISPATCH_WIDTH-1:0]                 pipeOperandTypeA;
    OperandType [DISPATCH_WIDTH-1:0]                 pipeOperandTypeB;
    logic [DISPATCH_WIDTH-1:0][REG_NUM_WIDTH-1:0]    pipeSrcRegA;
    logic [DISPATCH_WIDTH-1:0][REG_NUM_WIDTH-1:0]    pipeSrcRegB;
    logic [DISPATCH_WIDTH-1:0][REG_NUM_WIDTH-1:0]    pipeDstReg;
    logic [DISPATCH_WIDTH-1:0]                       pipeWriteReg;
    logic [DISPATCH_WIDTH-1:0][SLOT_WIDTH-1:0]       pipeIssuePtr;
    logic [DISPATCH_WIDTH-1:0][ACTIVE_PTR_WIDTH-1:0] pipePtrActive;

    // Sub-info layout depends on the queue class
    function automatic logic [SUB_INFO_WIDTH-1:0] packSubInfo(
        input OpClass                  opClass,
        input logic [OPCODE_WIDTH-1:0] opCode,
        input logic [DISP_WIDTH-1:0]   disp,
        input OperandType              typeA,
        input OperandType              typeB
    );
        AluCode                    aluCode;
        logic [SUB_INFO_WIDTH-1:0] subInfo;
        aluCode = AluCode'(opCode);
        case (opClass)
            OPC_INT:     subInfo = {aluCode, typeA, typeB, 4'b0000};
            OPC_BRANCH:  subInfo = {disp, typeA, typeB};
            // Mul/div code, then the upper-half flag
            OPC_COMPLEX: subInfo = {opCode[2:0], opCode[3], 8'h00};
            // Store flag, access size, pad, displacement
            OPC_MEM:     subInfo = {opCode[0], opCode[2:1], 1'b0, disp};
            default:     subInfo = '0;
        endcase
        return subInfo;
    endfunction

    // Lane valid bits, flushed by clear even while stalled
    always_ff @(posedge ctrl) begin
        if (reset || clear) begin
            pipeValid <= '0;
        end else if (!stall) begin
            pipeValid <= renValid;
        end
    end

    // Lane payload
    always_ff @(posedge ctrl) begin
        if (!stall) begin
            pipeOpClass      <= renOpClass;
            pipeOpCode       <= renOpCode;
            pipeDisp         <= renDisp;
            pipeOperandTypeA <= renOperandTypeA;
            pipeOperandTypeB <= renOperandTypeB;
            pipeSrcRegA      <= renSrcRegA;
            pipeSrcRegB      <= renSrcRegB;
            pipeDstReg       <= renDstReg;
            pipeWriteReg     <= renWriteReg;
            pipeIssuePtr     <= renIssuePtr;
            pipePtrActive    <= renActivePtr;
        end
    end

    // Entry formatting per lane
    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            // Disabled classes are dropped here
            laneWrite[i] = pipeValid[i] && !stall && !clear
                && classEnable[pipeOpClass[i]];
            laneWritePtr[i] = pipeIssuePtr[i];

            laneWriteEntry[i].opClass = pipeOpClass[i];
            laneWriteEntry[i].subInfo = packSubInfo(pipeOpClass[i], pipeOpCode[i],
                pipeDisp[i], pipeOperandTypeA[i], pipeOperandTypeB[i]);
            laneWriteEntry[i].srcValidA = (pipeOperandTypeA[i] == OPR_REG);
            laneWriteEntry[i].srcValidB = (pipeOperandTypeB[i] == OPR_REG);
            laneWriteEntry[i].srcRegA = pipeSrcRegA[i];
            laneWriteEntry[i].srcRegB = pipeSrcRegB[i];
            laneWriteEntry[i].dstReg = pipeDstReg[i];
            laneWriteEntry[i].writeReg = pipeWriteReg[i];
            laneWriteEntry[i].activePtr = pipePtrActive[i];
        end
    end

endmodule

`default_nettype wire

// File: hdl/issuePayloadRam.sv
//------------------------------------------------------------
// Issue-queue payload store
// Multi-lane write, slot release and a combinational read
// port that unpacks the selected entry
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module issuePayloadRam #(
    parameter  int DISPATCH_WIDTH = 2,
    parameter  int IQ_ENTRIES = 8,
    localparam int SLOT_WIDTH = $clog2(IQ_ENTRIES)
) (
    input  wire                                         ctrl,
    input  wire                                         reset,
    input  wire                                         clear,
    input  wire  [DISPATCH_WIDTH-1:0]                   laneWrite,
    input  wire  [DISPATCH_WIDTH-1:0][SLOT_WIDTH-1:0]   laneWritePtr,
    input  dispatchPkg::IssueEntry [DISPATCH_WIDTH-1:0] laneWriteEntry,
    input  wire                                         issueRelease,
    input  wire  [SLOT_WIDTH-1:0]                       releasePtr,
    input  wire  [SLOT_WIDTH-1:0]                       readPtr,
    output logic                                        readValid,
    output dispatchPkg::OpClass                         readOpClass,
    output logic [dispatchPkg::SUB_INFO_WIDTH-1:0]      readSubInfo,
    output logic                                        readSrcValidA,
    output logic                                        readSrcValidB,
    output logic [dispatchPkg::REG_NUM_WIDTH-1:0]       readSrcRegA,
    output logic [dispatchPkg::REG_NUM_WIDTH-1:0]       readSrcRegB,
    output logic [dispatchPkg::REG_NUM_WIDTH-1:0]       readDstReg,
    output logic                                        readWriteReg,
    output logic [dispatchPkg::ACTIVE_PTR_WIDTH-1:0]    readActivePtr
);

    import dispatchPkg::*;

    IssueEntry             entries [IQ_ENTRIES];
    logic [IQ_ENTRIES-1:0] slotValid;
    IssueEntry             readEntry;

    // Later lanes are written last, so lane 1 wins a shared slot
    always_ff @(posedge ctrl) begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (laneWrite[i]) begin
                entries[laneWritePtr[i]] <= laneWriteEntry[i];
            end
        end
    end

    // Release first so a same-slot write overrides it
    always_ff @(posedge ctrl) begin
        if (reset || clear) begin
            slotValid <= '0;
        end else begin
            if (issueRelease) begin
                slotValid[releasePtr] <= 1'b0;
            end
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                if (laneWrite[i]) begin
                    slotValid[laneWritePtr[i]] <= 1'b1;
                end
            end
        end
    end

    // Read port
    assign readEntry     = entries[readPtr];
    assign readValid     = slotValid[readPtr];
    assign readOpClass   = readEntry.opClass;
    assign readSubInfo   = readEntry.subInfo;
    assign readSrcValidA = readEntry.srcValidA;
    assign readSrcValidB = readEntry.srcValidB;
    assign readSrcRegA   = readEntry.srcRegA;
    assign readSrcRegB   = readEntry.srcRegB;
    assign readDstReg    = readEntry.dstReg;
    assign readWriteReg  = readEntry.writeReg;
    assign readActivePtr = readEntry.activePtr;

endmodule

`default_nettype wire

// File: hdl/dispatchUnit.sv
//------------------------------------------------------------
// Dispatch unit
// Control block, dispatch stage and issue payload store
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dispatchUnit #(
    parameter  int DISPATCH_WIDTH = 2,
    parameter  int IQ_ENTRIES = 8,
    localparam int SLOT_WIDTH = $clog2(IQ_ENTRIES)
) (
    input  wire                                 ctrl,
    input  wire                                 reset,
    input  wire                                 stallRequest,
    input  wire                                 flush,
    input  wire                                 cfgWrite,
    input  wire  [dispatchPkg::NUM_CLASSES-1:0] cfgEnable,

    // Rename lanes
    input  wire  [DISPATCH_WIDTH-1:0]           renValid,
    input  dispatchPkg::OpClass [DISPATCH_WIDTH-1:0] renOpClass,
    input  wire  [DISPATCH_WIDTH-1:0][dispatchPkg::OPCODE_WIDTH-1:0] renOpCode,
    input  wire  [DISPATCH_WIDTH-1:0][dispatchPkg::DISP_WIDTH-1:0] renDisp,
    input  dispatchPkg::OperandType [DISPATCH_WIDTH-1:0] renOperandTypeA,
    input  dispatchPkg::OperandType [DISPATCH_WIDTH-1:0] renOperandTypeB,
    input  wire  [DISPATCH_WIDTH-1:0][dispatchPkg::REG_NUM_WIDTH-1:0] renSrcRegA,
    input  wire  [DISPATCH_WIDTH-1:0][dispatchPkg::REG_NUM_WIDTH-1:0] renSrcRegB,
    input  wire  [DISPATCH_WIDTH-1:0][dispatchPkg::REG_NUM_WIDTH-1:0] renDstReg,
    input  wire  [DISPATCH_WIDTH-1:0]           renWriteReg,
    input  wire  [DISPATCH_WIDTH-1:0][SLOT_WIDTH-1:0] renIssuePtr,
    input  wire  [DISPATCH_WIDTH-1:0][dispatchPkg::ACTIVE_PTR_WIDTH-1:0] renActivePtr,

    // Issue side
    input  wire                                      issueRelease,
    input  wire  [SLOT_WIDTH-1:0]                    releasePtr,
    input  wire  [SLOT_WIDTH-1:0]                    readPtr,
    output logic                                     readValid,
    output dispatchPkg::OpClass                      readOpClass,
    output logic [dispatchPkg::SUB_INFO_WIDTH-1:0]   readSubInfo,
    output logic                                     readSrcValidA,
    output logic                                     readSrcValidB,
    output logic [dispatchPkg::REG_NUM_WIDTH-1:0]    readSrcRegA,
    output logic [dispatchPkg::REG_NUM_WIDTH-1:0]    readSrcRegB,
    output logic [dispatchPkg::REG_NUM_WIDTH-1:0]    readDstReg,
    output logic                                     readWriteReg,
    output logic [dispatchPkg::ACTIVE_PTR_WIDTH-1:0] readActivePtr
);

    import dispatchPkg::*;

    logic                                      stall;
    logic                                      clear;
    logic [NUM_CLASSES-1:0]                    classEnable;
    logic [DISPATCH_WIDTH-1:0]                 laneWrite;
    logic [DISPATCH_WIDTH-1:0][SLOT_WIDTH-1:0] laneWritePtr;
    IssueEntry [DISPATCH_WIDTH-1:0]            laneWriteEntry;

    dispatchControl control (
        .ctrl         (ctrl),
        .reset        (reset),
        .stallRequest (stallRequest),
        .flush        (flush),
        .cfgWrite     (cfgWrite),
        .cfgEnable    (cfgEnable),
        .stall        (stall),
        .clear        (clear),
        .classEnable  (classEnable)
    );

    dispatchStage #(
        .DISPATCH_WIDTH (DISPATCH_WIDTH),
        .IQ_ENTRIES     (IQ_ENTRIES)
    ) stage (
        .ctrl            (ctrl),
        .reset           (reset),
        .stall           (stall),
        .clear           (clear),
        .classEnable     (classEnable),
        .renValid        (renValid),
        .renOpClass      (renOpClass),
        .renOpCode       (renOpCode),
        .renDisp         (renDisp),
        .renOperandTypeA (renOperandTypeA),
        .renOperandTypeB (renOperandTypeB),
        .renSrcRegA      (renSrcRegA),
        .renSrcRegB      (renSrcRegB),
        .renDstReg       (renDstReg),
        .renWriteReg     (renWriteReg),
        .renIssuePtr     (renIssuePtr),
        .renActivePtr    (renActivePtr),
        .laneWrite       (laneWrite),
        .laneWritePtr    (laneWritePtr),
        .laneWriteEntry  (laneWriteEntry)
    );

    issuePayloadRam #(
        .DISPATCH_WIDTH (DISPATCH_WIDTH),
        .IQ_ENTRIES     (IQ_ENTRIES)
    ) payloadRam (
        .ctrl           (ctrl),
        .reset          (reset),
        .clear          (clear),
        .laneWrite      (laneWrite),
        .laneWritePtr   (laneWritePtr),
        .laneWriteEntry (laneWriteEntry),
        .issueRelease   (issueRelease),
        .releasePtr     (releasePtr),
        .readPtr        (readPtr),
        .readValid      (readValid),
        .readOpClass    (readOpClass),
        .readSubInfo    (readSubInfo),
        .readSrcValidA  (readSrcValidA),
        .readSrcValidB  (readSrcValidB),
        .readSrcRegA    (readSrcRegA),
        .readSrcRegB    (readSrcRegB),
        .readDstReg     (readDstReg),
        .readWriteReg   (readWriteReg),
        .readActivePtr  (readActivePtr)
    );

endmodule

`default_nettype wire

// File: bench/dispatchModel.sv
//------------------------------------------------------------
// Dispatch reference model
// Entry formatting from the packing rules and a mirror of the
// pipeline register, control state and payload slots
//------------------------------------------------------------
`default_nettype none

package dispatchModel;

    import dispatchPkg::*;

    localparam int LANES = 2;
    localparam int SLOTS = 8;
    localparam int SLOT_BITS = $clog2(SLOTS);

    // One renamed operation as presented on a lane
    typedef struct packed {
        logic                        valid;
        OpClass                      opClass;
        logic [OPCODE_WIDTH-1:0]     opCode;
        logic [DISP_WIDTH-1:0]       disp;
        OperandType                  typeA, typeB;
        logic [REG_NUM_WIDTH-1:0]    srcRegA, srcRegB, dstReg;
        logic                        writeReg;
        logic [SLOT_BITS-1:0]        issuePtr;
        logic [ACTIVE_PTR_WIDTH-1:0] activePtr;
    } RenOp;

    RenOp [LANES-1:0]       pipeMirror = '0;
    IssueEntry              slotMirror [SLOTS];
    logic [SLOTS-1:0]       slotValidMirror = '0;
    logic                   clearMirror = 1'b0;
    logic [NUM_CLASSES-1:0] enableMirror = '1;

    // Bit positions counted from the top, unused bits stay zero
    function automatic logic [SUB_INFO_WIDTH-1:0] formatSubInfo(input RenOp op);
        logic [SUB_INFO_WIDTH-1:0] info;
        info = '0;
        case (op.opClass)
            OPC_INT:     info[11:4] = {op.opCode, op.typeA, op.typeB};
            OPC_BRANCH:  info[11:0] = {op.disp, op.typeA, op.typeB};
            OPC_COMPLEX: info[11:8] = {op.opCode[2:0], op.opCode[3]};
            OPC_MEM: begin
                info[11:9] = {op.opCode[0], op.opCode[2:1]};
                info[7:0]  = op.disp;
            end
            default:     info = '0;
        endcase
        return info;
    endfunction

    // One rising edge, slot updates use the state from before it
    function automatic void applyEdge(input logic rst, input logic stallReq,
        input logic flushIn, input logic cfgWr, input logic [NUM_CLASSES-1:0] cfgEn,
        input logic relStrobe, input logic [SLOT_BITS-1:0] relPtr,
        input RenOp [LANES-1:0] ops);
        logic [LANES-1:0] laneWrites;
        IssueEntry        entry;
        for (int i = 0; i < LANES; i++) begin
            laneWrites[i] = pipeMirror[i].valid && !stallReq && !clearMirror && !rst
                && enableMirror[pipeMirror[i].opClass];
        end
        if (rst || clearMirror) begin
            slotValidMirror = '0;
        end else if (relStrobe) begin
            slotValidMirror[relPtr] = 1'b0;
        end
        // Lane 1 goes last and so owns a shared slot
        for (int i = 0; i < LANES; i++) begin
            if (laneWrites[i]) begin
                entry.opClass   = pipeMirror[i].opClass;
                entry.subInfo   = formatSubInfo(pipeMirror[i]);
                entry.srcValidA = pipeMirror[i].typeA == OPR_REG;
                entry.srcValidB = pipeMirror[i].typeB == OPR_REG;
                entry.srcRegA   = pipeMirror[i].srcRegA;
                entry.srcRegB   = pipeMirror[i].srcRegB;
                entry.dstReg    = pipeMirror[i].dstReg;
                entry.writeReg  = pipeMirror[i].writeReg;
                entry.activePtr = pipeMirror[i].activePtr;
                slotMirror[pipeMirror[i].issuePtr] = entry;
                slotValidMirror[pipeMirror[i].issuePtr] = 1'b1;
            end
        end
        if (!stallReq) begin
            pipeMirror = ops;
        end
        // Clear empties the pipe even under stall
        if (rst || clearMirror) begin
            for (int i = 0; i < LANES; i++) begin
                pipeMirror[i].valid = 1'b0;
            end
        end
        clearMirror = !rst && flushIn;
        if (rst) begin
            enableMirror = '1;
        end else if (cfgWr) begin
            enableMirror = cfgEn;
        end
    endfunction

endpackage

`default_nettype wire

// File: bench/dispatchTb.sv
//------------------------------------------------------------
// Dispatch unit testbench
// Random rename traffic with stalls, class masks, flushes and
// releases, checked against the reference model
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dispatchTb;

    import dispatchPkg::*;
    import dispatchModel::*;

    localparam int RESET_CYCLES = 5;
    localparam int PHASE_CYCLES = 250;
    localparam int DRAIN_CYCLES = 4;
    localparam int TOTAL_CYCLES = RESET_CYCLES + SLOTS + 4 * PHASE_CYCLES + DRAIN_CYCLES;
    localparam int WATCHDOG_NS = (TOTAL_CYCLES + 50) * 8;

    logic                   ctrl = 1'b0;
    logic                   reset, stallRequest, flush, cfgWrite, issueRelease;
    logic [NUM_CLASSES-1:0] cfgEnable;
    logic [SLOT_BITS-1:0]   releasePtr, readPtr;
    logic [SLOT_BITS-1:0]   writtenPtr;
    RenOp [LANES-1:0]       renOps;
    integer                 seed = 91397;

    // Lane ports unpacked from renOps
    logic [LANES-1:0]                        renValid, renWriteReg;
    OpClass [LANES-1:0]                      renOpClass;
    logic [LANES-1:0][OPCODE_WIDTH-1:0]      renOpCode;
    logic [LANES-1:0][DISP_WIDTH-1:0]        renDisp;
    OperandType [LANES-1:0]                  renOperandTypeA, renOperandTypeB;
    logic [LANES-1:0][REG_NUM_WIDTH-1:0]     renSrcRegA, renSrcRegB, renDstReg;
    logic [LANES-1:0][SLOT_BITS-1:0]         renIssuePtr;
    logic [LANES-1:0][ACTIVE_PTR_WIDTH-1:0]  renActivePtr;

    // Read port
    logic                        readValid, readSrcValidA, readSrcValidB, readWriteReg;
    OpClass                      readOpClass;
    logic [SUB_INFO_WIDTH-1:0]   readSubInfo;
    logic [REG_NUM_WIDTH-1:0]    readSrcRegA, readSrcRegB, readDstReg;
    logic [ACTIVE_PTR_WIDTH-1:0] readActivePtr;

    dispatchUnit #(.DISPATCH_WIDTH (LANES), .IQ_ENTRIES (SLOTS)) DUT (.*);

    always #4 ctrl = ~ctrl;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            renValid[i]        = renOps[i].valid;
            renOpClass[i]      = renOps[i].opClass;
            renOpCode[i]       = renOps[i].opCode;
            renDisp[i]         = renOps[i].disp;
            renOperandTypeA[i] = renOps[i].typeA;
            renOperandTypeB[i] = renOps[i].typeB;
            renSrcRegA[i]      = renOps[i].srcRegA;
            renSrcRegB[i]      = renOps[i].srcRegB;
            renDstReg[i]       = renOps[i].dstReg;
            renWriteReg[i]     = renOps[i].writeReg;
            renIssuePtr[i]     = renOps[i].issuePtr;
            renActivePtr[i]    = renOps[i].activePtr;
        end
    end

    function automatic logic chance(input int percent);
        return ($unsigned($random(seed)) % 100) < percent;
    endfunction

    function automatic RenOp randomOp();
        logic [63:0] bits;
        RenOp        op;
        bits = {$random(seed), $random(seed)};
        op = bits[$bits(RenOp)-1:0];
        op.valid = chance(85);
        return op;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected 0x%0h got 0x%0h",
                $time, name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Model takes the inputs seen at the edge, then drive 1 ns later
    task automatic advance();
        @(posedge ctrl);
        // Lane 1 slot that this edge writes
        writtenPtr = pipeMirror[1].issuePtr;
        applyEdge(reset, stallRequest, flush, cfgWrite, cfgEnable, issueRelease,
            releasePtr, renOps);
        #1;
    endtask

    task automatic driveRandom(input int stallPct, input int cfgPct, input int flushPct,
        input int relPct);
        logic [63:0] bits;
        // Operations stay put until an edge without stall has taken them
        if (!stallRequest) begin
            for (int i = 0; i < LANES; i++) begin
                renOps[i] = randomOp();
            end
            if (chance(25)) begin
                renOps[1].issuePtr = renOps[0].issuePtr;
            end
        end
        bits = {$random(seed), $random(seed)};
        stallRequest = stallRequest ? chance(70) : chance(stallPct);
        flush = chance(flushPct);
        cfgWrite = chance(cfgPct);
        cfgEnable = bits[3:0];
        issueRelease = chance(relPct);
        releasePtr = chance(30) ? pipeMirror[0].issuePtr : bits[8 +: SLOT_BITS];
        // Often read back the slot just written
        readPtr = chance(30) ? writtenPtr : bits[16 +: SLOT_BITS];
    endtask

    task automatic checkReadPort();
        IssueEntry want;
        #2;
        want = slotMirror[readPtr];
        checkValue("readValid", 32'(slotValidMirror[readPtr]), 32'(readValid));
        if (slotValidMirror[readPtr]) begin
            checkValue("readOpClass", 32'(want.opClass), 32'(readOpClass));
            checkValue("readSubInfo", 32'(want.subInfo), 32'(readSubInfo));
            checkValue("readSrcValidA", 32'(want.srcValidA), 32'(readSrcValidA));
            checkValue("readSrcValidB", 32'(want.srcValidB), 32'(readSrcValidB));
            checkValue("readSrcRegA", 32'(want.srcRegA), 32'(readSrcRegA));
            checkValue("readSrcRegB", 32'(want.srcRegB), 32'(readSrcRegB));
            checkValue("readDstReg", 32'(want.dstReg), 32'(readDstReg));
            checkValue("readWriteReg", 32'(want.writeReg), 32'(readWriteReg));
            checkValue("readActivePtr", 32'(want.activePtr), 32'(readActivePtr));
        end
    endtask

    task automatic runPhase(input int cycles, input int stallPct, input int cfgPct,
        input int flushPct, input int relPct);
        repeat (cycles) begin
            advance();
            driveRandom(stallPct, cfgPct, flushPct, relPct);
            checkReadPort();
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset = 1'b1;
        stallRequest = 1'b0;
        flush = 1'b0;
        cfgWrite = 1'b0;
        cfgEnable = '1;
        issueRelease = 1'b0;
        releasePtr = '0;
        readPtr = '0;
        renOps = '0;
        repeat (RESET_CYCLES) begin
            advance();
        end
        reset = 1'b0;
        // Sweep of empty slots after reset
        for (int s = 0; s < SLOTS; s++) begin
            advance();
            readPtr = SLOT_BITS'(s);
            checkReadPort();
            checkValue("readValid", 32'd0, 32'(readValid));
        end
        runPhase(PHASE_CYCLES, 0, 0, 0, 0);
        runPhase(PHASE_CYCLES, 20, 0, 0, 10);
        runPhase(PHASE_CYCLES, 0, 10, 0, 10);
        runPhase(PHASE_CYCLES, 5, 5, 6, 30);
        // Idle inputs while the last operations drain
        repeat (DRAIN_CYCLES) begin
            advance();
            // Operations held under stall are still taken once it drops
            if (!stallRequest) begin
                renOps = '0;
            end
            stallRequest = 1'b0;
            flush = 1'b0;
            cfgWrite = 1'b0;
            issueRelease = 1'b0;
            readPtr = writtenPtr;
            checkReadPort();
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hdl/dispatchPkg.sv
hdl/dispatchControl.sv
hdl/dispatchStage.sv
hdl/issuePayloadRam.sv
hdl/dispatchUnit.sv
bench/dispatchModel.sv
bench/dispatchTb.sv
